/* Bender.yml */
package:
  name: memctl

sources:
  - files:
      - hw/memctl_pkg.sv
      - hw/wr_data_regs.sv
      - hw/wr_seq.sv
      - hw/rd_window.sv
      - hw/word_ram.sv
      - hw/memctl_top.sv
  - target: test
    files:
      - testbench/memctl_properties.sv
      - testbench/memctl_tb.sv

/* hw/memctl_pkg.sv */
// memctl_pkg: bus widths, write data source codes, write length codes, RAM depth
package memctl_pkg;

    localparam int addr_w = 24;     // byte address
    localparam int data_w = 32;     // cpu datum
    localparam int bus_w  = 16;     // ram bus, two byte lanes

    // ram model depth in 16-bit words, upper address bits wrap
    localparam int ram_words = 4096;

    // write data source select
    localparam logic [1:0] dsel_alu = 2'd0;
    localparam logic [1:0] dsel_pc  = 2'd1;
    localparam logic [1:0] dsel_sr  = 2'd2;
    localparam logic [1:0] dsel_src = 2'd3;     // copy kept for exchange

    // write length, one-hot
    localparam logic [2:0] len_byte = 3'b001;
    localparam logic [2:0] len_word = 3'b010;
    localparam logic [2:0] len_long = 3'b100;

    // upper 16 address bits of an interrupt vector read
    localparam logic [15:0] irq_page = 16'hffff;

endpackage

/* hw/memctl_top.sv */
// memctl_top: memory access unit with write data regs, write sequencer, read window and RAM
module memctl_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cen,
    input  logic                          ldram_en,
    input  logic [memctl_pkg::addr_w-1:0] pc,
    input  logic [memctl_pkg::addr_w-1:0] xsp,
    input  logic [memctl_pkg::addr_w-1:0] xde,
    input  logic [memctl_pkg::addr_w-1:0] xhl,
    input  logic [memctl_pkg::addr_w-1:0] idx_addr,
    input  logic                          sel_xsp,
    input  logic                          sel_xde,
    input  logic                          sel_xhl,
    input  logic                          rda_imm,
    input  logic                          rda_irq,
    input  logic                          wra_imm,
    input  logic                          sel_op8,
    input  logic                          sel_op16,
    input  logic [15:0]                   op16,
    input  logic [memctl_pkg::data_w-1:0] imm,
    input  logic                          sel_imm,
    input  logic [1:0]                    data_sel,
    input  logic [1:0]                    regs_we,
    input  logic [memctl_pkg::data_w-1:0] src_out,
    input  logic [memctl_pkg::data_w-1:0] alu_dout,
    input  logic [15:0]                   sr,
    input  logic                          idx_wr,
    input  logic [2:0]                    len,
    output logic [memctl_pkg::data_w-1:0] dout,
    output logic                          ram_rdy
);

    logic [memctl_pkg::data_w-1:0] eff_data;
    logic [memctl_pkg::addr_w-1:0] rd_bus_addr;
    logic [memctl_pkg::addr_w-1:0] ram_addr;
    logic [memctl_pkg::bus_w-1:0]  ram_din;
    logic [memctl_pkg::bus_w-1:0]  ram_dout;
    logic [1:0]                    ram_we;
    logic                          wr_busy;

    // names match across the hierarchy
    wr_data_regs u_data (.*);

    wr_seq u_wr (.*);   // sole driver of the ram bus

    rd_window u_rd (.*);

    word_ram u_ram (.*);

endmodule

/* hw/rd_window.sv */
// rd_window: read address select, four-byte read window with shift reuse, opcode save/restore
module rd_window (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cen,
    input  logic                          ldram_en,
    input  logic [memctl_pkg::addr_w-1:0] pc,
    input  logic [memctl_pkg::addr_w-1:0] xsp,
    input  logic [memctl_pkg::addr_w-1:0] xde,
    input  logic [memctl_pkg::addr_w-1:0] xhl,
    input  logic [memctl_pkg::addr_w-1:0] idx_addr,
    input  logic [memctl_pkg::data_w-1:0] imm,
    input  logic                          sel_xsp,
    input  logic                          sel_xde,
    input  logic                          sel_xhl,
    input  logic                          rda_imm,
    input  logic                          rda_irq,
    input  logic [memctl_pkg::bus_w-1:0]  ram_dout,
    input  logic                          wr_busy,
    output logic [memctl_pkg::addr_w-1:0] rd_bus_addr,
    output logic [memctl_pkg::data_w-1:0] dout,
    output logic                          ram_rdy
);

    logic [memctl_pkg::addr_w-1:0] rd_addr;
    logic [memctl_pkg::addr_w-1:0] win_addr;
    logic [memctl_pkg::addr_w-1:0] op_addr;
    logic [memctl_pkg::addr_w-1:0] ram_ptr;    // word on the bus this cycle
    logic [memctl_pkg::addr_w-1:0] byte_addr [4];
    logic [3:0][7:0] win;
    logic [3:0][7:0] op_win;
    logic [3:0][7:0] lane;
    logic [3:0] vld;
    logic [3:0] pend;
    logic [3:0] op_vld;
    logic [3:0] hit;
    logic [3:0] keep;
    logic [1:0] shift;
    logic [1:0] first_pend;
    logic       ldram_l;
    logic       save;
    logic       restore;
    logic       miss;

    always_comb begin
        if (!ldram_en)    rd_addr = pc;
        else if (sel_xsp) rd_addr = xsp;
        else if (sel_xde) rd_addr = xde;
        else if (sel_xhl) rd_addr = xhl;
        else if (rda_imm) rd_addr = {8'd0, imm[31:16]};
        else if (rda_irq) rd_addr = {memctl_pkg::irq_page, imm[7:0]};
        else              rd_addr = idx_addr;
    end

    // how many held bytes can move down instead of being fetched again
    always_comb begin
        shift = 2'd0;
        if (rd_addr == win_addr + 24'd1 && vld[3:1] == 3'b111) begin
            shift = 2'd1;
        end else if (rd_addr == win_addr + 24'd2 && vld[3:2] == 2'b11) begin
            shift = 2'd2;
        end else if (rd_addr == win_addr + 24'd3 && vld[3]) begin
            shift = 2'd3;
        end
    end

    assign keep       = (shift == 2'd0) ? 4'h0 : 4'hf >> shift;
    assign first_pend = 2'd0 - shift;   // slot of the first byte to fetch
    assign save       = ldram_en && !ldram_l;
    assign restore    = !ldram_en && ldram_l;
    assign miss       = pend == 4'd0 && (rd_addr != win_addr || vld != 4'hf);

    // each pending slot takes its lane when the bus word covers it
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            byte_addr[i] = win_addr + 24'(i);
            hit[i]  = pend[i] && byte_addr[i][23:1] == ram_ptr[23:1];
            lane[i] = byte_addr[i][0] ? ram_dout[15:8] : ram_dout[7:0];
        end
    end

    always_comb begin
        rd_bus_addr = ram_ptr;
        if (!wr_busy && !restore) begin
            if (pend != 4'd0)
                rd_bus_addr = ram_ptr + 24'd2;
            else if (miss)
                rd_bus_addr = rd_addr + {22'd0, first_pend};
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            win_addr <= '0;
            ram_ptr  <= '0;
            vld      <= 4'd0;
            pend     <= 4'd0;
            op_vld   <= 4'd0;
            ldram_l  <= 1'b0;
        end else if (cen) begin
            ldram_l <= ldram_en;
            ram_ptr <= rd_bus_addr;
            if (wr_busy) begin
                // memory is changing under both windows
                vld    <= 4'd0;
                pend   <= 4'd0;
                op_vld <= 4'd0;
            end else begin
                if (save) op_vld <= vld;
                if (restore) begin
                    win_addr <= op_addr;
                    vld      <= op_vld;
                    pend     <= 4'd0;
                end else if (pend != 4'd0) begin
                    vld  <= vld | hit;
                    pend <= pend & ~hit;
                end else if (miss) begin
                    win_addr <= rd_addr;
                    vld      <= keep;
                    pend     <= ~keep;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && !wr_busy) begin
            if (save) begin
                op_addr <= win_addr;   // opcode window parked during operand load
                op_win  <= win;
            end
            if (restore) begin
                win <= op_win;
            end else if (pend != 4'd0) begin
                for (int i = 0; i < 4; i++) begin
                    if (hit[i]) win[i] <= lane[i];
                end
            end else if (miss) begin
                win <= win >> {shift, 3'b000};
            end
        end
    end

    assign ram_rdy = &vld && win_addr == rd_addr && !wr_busy;
    assign dout    = win;   // byte 0 is the lowest address

endmodule

/* hw/word_ram.sv */
// word_ram: 16-bit RAM model with byte-lane writes and combinational read
module word_ram (
    input  logic                          clk,
    input  logic [memctl_pkg::addr_w-1:0] ram_addr,
    input  logic [memctl_pkg::bus_w-1:0]  ram_din,
    input  logic [1:0]                    ram_we,
    output logic [memctl_pkg::bus_w-1:0]  ram_dout
);

    logic [memctl_pkg::bus_w-1:0] mem [memctl_pkg::ram_words];
    logic [$clog2(memctl_pkg::ram_words)-1:0] widx;

    // byte address to word index, higher bits dropped so memory wraps
    assign widx     = ram_addr[$clog2(memctl_pkg::ram_words):1];
    assign ram_dout = mem[widx];

    always_ff @(posedge clk) begin
        if (ram_we[0]) mem[widx][7:0]  <= ram_din[7:0];    // even byte
        if (ram_we[1]) mem[widx][15:8] <= ram_din[15:8];   // odd byte
    end

endmodule

/* hw/wr_data_regs.sv */
// wr_data_regs: source register copy and write data source select
module wr_data_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cen,
    input  logic [1:0]                    regs_we,
    input  logic [memctl_pkg::data_w-1:0] src_out,
    input  logic [1:0]                    data_sel,
    input  logic [memctl_pkg::data_w-1:0] alu_dout,
    input  logic [memctl_pkg::addr_w-1:0] pc,
    input  logic [15:0]                   sr,
    input  logic [memctl_pkg::data_w-1:0] imm,
    input  logic                          sel_imm,
    output logic [memctl_pkg::data_w-1:0] eff_data
);

    logic [15:0] src_cpy;   // low half of last register written

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            src_cpy <= '0;
        end else if (cen && regs_we != 2'd0) begin
            src_cpy <= src_out[15:0];
        end
    end

    always_comb begin
        case (data_sel)
            memctl_pkg::dsel_pc:  eff_data = {8'd0, pc};
            memctl_pkg::dsel_sr:  eff_data = {16'd0, sr};
            memctl_pkg::dsel_src: eff_data = {16'd0, src_cpy};
            default:              eff_data = alu_dout;
        endcase
        // immediate replaces the low half only
        if (sel_imm) begin
            eff_data[15:0] = imm[15:0];
        end
    end

endmodule

/* hw/wr_seq.sv */
// wr_seq: write address select and byte/word/long write split into 16-bit bus cycles
module wr_seq (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cen,
    input  logic                          idx_wr,
    input  logic [2:0]                    len,
    input  logic [memctl_pkg::data_w-1:0] eff_data,
    input  logic [memctl_pkg::addr_w-1:0] rd_bus_addr,
    input  logic                          sel_op8,
    input  logic                          sel_op16,
    input  logic                          sel_xsp,
    input  logic                          wra_imm,
    input  logic [15:0]                   op16,
    input  logic [memctl_pkg::addr_w-1:0] xsp,
    input  logic [memctl_pkg::data_w-1:0] imm,
    input  logic [memctl_pkg::addr_w-1:0] idx_addr,
    output logic [memctl_pkg::addr_w-1:0] ram_addr,
    output logic [memctl_pkg::bus_w-1:0]  ram_din,
    output logic [1:0]                    ram_we,
    output logic                          wr_busy
);

    logic [memctl_pkg::addr_w-1:0] wr_addr;
    logic [1:0] step;       // 0 idle or first cycle, 1 second, 2 third
    logic       odd;

    always_comb begin
        if (sel_op8)       wr_addr = {16'd0, op16[7:0]};
        else if (sel_op16) wr_addr = {8'd0, op16};
        else if (sel_xsp)  wr_addr = xsp;
        else if (wra_imm)  wr_addr = {8'd0, imm[31:16]};
        else               wr_addr = idx_addr;
    end

    assign odd = wr_addr[0];   // sources are held for the whole write

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ram_addr <= '0;
            ram_we   <= 2'b00;
            wr_busy  <= 1'b0;
            step     <= 2'd0;
        end else if (cen) begin
            ram_we  <= 2'b00;
            wr_busy <= 1'b0;
            if (idx_wr && step == 2'd0) begin
                ram_addr <= wr_addr;
                wr_busy  <= 1'b1;
                if (len == memctl_pkg::len_byte) begin
                    ram_we <= {odd, ~odd};
                end else if (odd) begin
                    ram_we <= 2'b10;            // first byte in the high lane
                    step   <= 2'd1;
                end else begin
                    ram_we <= 2'b11;
                    step   <= (len == memctl_pkg::len_long) ? 2'd1 : 2'd0;
                end
            end else if (step != 2'd0) begin
                ram_addr <= ram_addr + 24'd2;
                wr_busy  <= 1'b1;
                if (step == 2'd2) begin
                    ram_we <= 2'b01;            // last byte of an odd long
                    step   <= 2'd0;
                end else if (!odd) begin
                    ram_we <= 2'b11;            // upper half of an even long
                    step   <= 2'd0;
                end else if (len == memctl_pkg::len_word) begin
                    ram_we <= 2'b01;
                    step   <= 2'd0;
                end else begin
                    ram_we <= 2'b11;            // middle two bytes of an odd long
                    step   <= 2'd2;
                end
            end else begin
                ram_addr <= rd_bus_addr;   // read side owns the bus when idle
            end
        end
    end

    // lane data for each bus step
    always_ff @(posedge clk) begin
        if (cen) begin
            if (idx_wr && step == 2'd0) begin
                if (len == memctl_pkg::len_byte || odd) begin
                    ram_din <= {2{eff_data[7:0]}};
                end else begin
                    ram_din <= eff_data[15:0];
                end
            end else if (step == 2'd2) begin
                ram_din <= {2{eff_data[31:24]}};
            end else if (step == 2'd1) begin
                if (!odd)                                ram_din <= eff_data[31:16];
                else if (len == memctl_pkg::len_word)    ram_din <= {2{eff_data[15:8]}};
                else                                     ram_din <= eff_data[23:8];
            end
        end
    end

endmodule

/* src.f */
hw/memctl_pkg.sv
hw/wr_data_regs.sv
hw/wr_seq.sv
hw/rd_window.sv
hw/word_ram.sv
hw/memctl_top.sv
testbench/memctl_properties.sv
testbench/memctl_tb.sv

/* testbench/memctl_properties.sv */
// memctl_properties: write sequencer assertions on lane enables, busy length and reset, with bind
module memctl_properties (
    input logic       clk,
    input logic       rst,
    input logic       cen,
    input logic [1:0] ram_we,
    input logic       wr_busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;
    logic [2:0] busy_len;   // enabled cycles seen with wr_busy high

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy_len <= '0;
        end else if (cen) begin
            busy_len <= wr_busy ? busy_len + 3'd1 : 3'd0;
        end
    end

    we_in_busy: assert property (@(posedge clk) disable iff (rst) ram_we != 2'b00 |-> wr_busy)
        else begin
            fail_cnt++;
            $error("lane enable active outside a write");
        end

    // odd long is the longest write
    busy_max: assert property (@(posedge clk) disable iff (rst) busy_len <= 3'd3)
        else begin
            fail_cnt++;
            $error("wr_busy high for more than 3 enabled cycles");
        end

    we_after_reset: assert property (@(posedge clk) $fell(rst) |-> ram_we == 2'b00)
        else begin
            fail_cnt++;
            $error("lane enable active in the cycle after reset");
        end

endmodule

bind wr_seq memctl_properties u_props (.*);

/* testbench/memctl_tb.sv */
// memctl_tb: stimulus, lcg, reference memory and function, compare tasks, checker and report
module memctl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk, rst, cen, ldram_en, idx_wr, ram_rdy, r0, rd_req;
    logic sel_xsp, sel_xde, sel_xhl, rda_imm, rda_irq, wra_imm, sel_op8, sel_op16, sel_imm;
    logic [memctl_pkg::addr_w-1:0] pc, xsp, xde, xhl, idx_addr, exp_addr, a;
    logic [memctl_pkg::data_w-1:0] imm, src_out, alu_dout, dout, d0, wd;
    logic [15:0] op16, sr;
    logic [1:0] data_sel, regs_we;
    logic [2:0] len;
    logic [7:0] ref_mem [2 * memctl_pkg::ram_words];   // byte mirror of the ram
    logic [31:0] seed;
    string rd_name;
    int checks = 0;
    int errors = 0;
    int chk0 = 0;
    int err0 = 0;

    memctl_top dut0 (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // four model bytes, lowest address in the low byte, ram wraps
    function automatic logic [memctl_pkg::data_w-1:0] expect_dout(
        logic [memctl_pkg::addr_w-1:0] addr);
        logic [memctl_pkg::data_w-1:0] v;
        for (int i = 0; i < 4; i++) begin
            v[8*i +: 8] = ref_mem[(int'(addr) + i) % (2 * memctl_pkg::ram_words)];
        end
        return v;
    endfunction

    task automatic model_write(logic [memctl_pkg::addr_w-1:0] addr,
                               logic [memctl_pkg::data_w-1:0] data, logic [2:0] wlen);
        int n;
        n = (wlen == memctl_pkg::len_byte) ? 1 : (wlen == memctl_pkg::len_word) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[(int'(addr) + i) % (2 * memctl_pkg::ram_words)] = data[8*i +: 8];
        end
    endtask

    task automatic check_data(string name, logic [memctl_pkg::data_w-1:0] exp,
                              logic [memctl_pkg::data_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_rdy(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic end_test(string name);
        $display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
        chk0 = checks;
        err0 = errors;
    endtask

    task automatic report_and_finish();
        errors += dut0.u_wr.u_props.fail_cnt;   // assertion failures count too
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(string what);
        $display("timeout: ram_rdy did not rise within 20 cycles during %s", what);
        errors++;
        report_and_finish();
    endtask

    task automatic wait_ready(string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!ram_rdy) begin
            n++;
            if (n == 20) abort_on_timeout(what);
            @(negedge clk);
        end
        @(posedge clk);
        #5;
    endtask

    // the checker below clears rd_req once dout is compared
    task automatic read_check(string name, logic [memctl_pkg::addr_w-1:0] addr);
        int n;
        n = 0;
        exp_addr = addr;
        rd_name = name;
        rd_req = 1'b1;
        @(posedge clk);
        while (rd_req) begin
            n++;
            if (n == 20) abort_on_timeout(name);
            @(posedge clk);
        end
        #5;
    endtask

    task automatic write_mem(string name, logic [memctl_pkg::addr_w-1:0] addr,
                             logic [memctl_pkg::data_w-1:0] data, logic [2:0] wlen);
        len = wlen;
        idx_wr = 1'b1;
        @(posedge clk);
        #5;
        idx_wr = 1'b0;
        wait_ready(name);   // sources held until the window is back
        model_write(addr, data, wlen);
    endtask

    task automatic write_and_read(string name, logic [memctl_pkg::addr_w-1:0] addr,
                                  logic [memctl_pkg::data_w-1:0] data);
        write_mem(name, addr, data, memctl_pkg::len_long);
        pc = addr;
        read_check(name, addr);
    endtask

    always @(negedge clk) begin
        if (rd_req && ram_rdy) begin
            check_data(rd_name, expect_dout(exp_addr), dout);
            rd_req = 1'b0;
        end
    end

    initial begin
        seed = 32'hb31956d9;
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        {ldram_en, idx_wr, rd_req, sel_imm} = '0;
        {sel_xsp, sel_xde, sel_xhl, rda_imm, rda_irq, wra_imm, sel_op8, sel_op16} = '0;
        {pc, xsp, xde, xhl, idx_addr, imm, src_out, alu_dout, op16, sr, regs_we} = '0;
        data_sel = memctl_pkg::dsel_alu;
        len = memctl_pkg::len_byte;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_rdy("reset_rdy", 1'b0, ram_rdy);
        @(posedge clk);
        #5;
        rst = 1'b0;

        // fill bytes 0..0x20f and the vector page image at 0x1f00
        for (int i = 0; i < 196; i++) begin
            idx_addr = (i < 132) ? 24'(4 * i) : 24'('h1f00 + 4 * (i - 132));
            alu_dout = next_rand();
            write_mem("fill", idx_addr, alu_dout, memctl_pkg::len_long);
        end

        for (int i = 0; i < 12; i++) begin
            a = 24'(next_rand() & 32'h1fe) | 24'(i % 2);
            idx_addr = a;
            alu_dout = next_rand();
            write_mem("wr_len", a, alu_dout, 3'(1 << (i % 3)));
            pc = a;
            read_check("rd_len", a);
        end
        end_test("write lengths");

        pc = 24'(next_rand() & 32'h1e0);
        read_check("seq_base", pc);
        for (int i = 0; i < 8; i++) begin
            pc = pc + 24'((i % 4 == 3) ? 5 : i % 4 + 1);
            read_check("seq_step", pc);
        end
        end_test("window reuse");

        xsp = 24'(next_rand() & 32'h1ff);
        xde = 24'(next_rand() & 32'h1ff);
        xhl = 24'(next_rand() & 32'h1ff);
        idx_addr = 24'(next_rand() & 32'h1ff);
        imm = next_rand() & 32'h01ff00ff;
        {sel_xsp, sel_xde, sel_xhl, rda_imm, rda_irq, ldram_en} = 6'h3f;
        read_check("rd_xsp", xsp);
        sel_xsp = 1'b0;
        read_check("rd_xde", xde);
        sel_xde = 1'b0;
        read_check("rd_xhl", xhl);
        sel_xhl = 1'b0;
        read_check("rd_imm", {8'd0, imm[31:16]});
        rda_imm = 1'b0;
        read_check("rd_irq", {memctl_pkg::irq_page, imm[7:0]});
        rda_irq = 1'b0;
        read_check("rd_idx", idx_addr);
        ldram_en = 1'b0;
        read_check("rd_pc", pc);
        op16 = 16'(next_rand() & 32'h1ff);
        xsp = 24'(next_rand() & 32'h1ff);
        imm = next_rand() & 32'h01ff0000;
        alu_dout = next_rand();
        {sel_op8, sel_op16, sel_xsp, wra_imm} = 4'hf;
        write_and_read("wr_op8", {16'd0, op16[7:0]}, alu_dout);
        sel_op8 = 1'b0;
        write_and_read("wr_op16", {8'd0, op16}, alu_dout);
        sel_op16 = 1'b0;
        write_and_read("wr_xsp", xsp, alu_dout);
        sel_xsp = 1'b0;
        write_and_read("wr_imm", {8'd0, imm[31:16]}, alu_dout);
        wra_imm = 1'b0;
        write_and_read("wr_idx", idx_addr, alu_dout);
        end_test("address sources");

        idx_addr = 24'(next_rand() & 32'h1ff);
        pc = 24'(next_rand() & 32'h1ff);
        data_sel = memctl_pkg::dsel_pc;
        write_and_read("wr_pc", idx_addr, {8'd0, pc});
        sr = 16'(next_rand());
        data_sel = memctl_pkg::dsel_sr;
        idx_addr = idx_addr + 24'd5;
        write_and_read("wr_sr", idx_addr, {16'd0, sr});
        src_out = next_rand();
        regs_we = 2'b10;
        @(posedge clk);
        #5;
        regs_we = 2'b00;
        wd = {16'd0, src_out[15:0]};
        src_out = next_rand();   // copy must not follow
        data_sel = memctl_pkg::dsel_src;
        idx_addr = idx_addr + 24'd3;
        write_and_read("wr_src", idx_addr, wd);
        alu_dout = next_rand();
        imm = next_rand();
        data_sel = memctl_pkg::dsel_alu;
        sel_imm = 1'b1;
        write_and_read("wr_imm_low", idx_addr, {alu_dout[31:16], imm[15:0]});
        sel_imm = 1'b0;
        end_test("data sources");

        pc = 24'(next_rand() & 32'h1ff);
        read_check("op_pc", pc);
        idx_addr = 24'(next_rand() & 32'h1ff);
        ldram_en = 1'b1;
        read_check("operand", idx_addr);
        ldram_en = 1'b0;
        @(negedge clk);     // restore cycle
        @(negedge clk);
        check_rdy("restore_rdy", 1'b1, ram_rdy);
        check_data("restore_dout", expect_dout(pc), dout);
        @(posedge clk);
        #5;
        end_test("opcode restore");

        idx_addr = pc + 24'd1;
        alu_dout = next_rand();
        write_mem("wr_under", idx_addr, alu_dout, memctl_pkg::len_word);
        read_check("rd_under", pc);
        pc = pc + 24'd6;
        @(posedge clk);
        #5;
        cen = 1'b0;         // freeze in the middle of the refill
        @(negedge clk);
        d0 = dout;
        r0 = ram_rdy;
        repeat (4) begin
            @(negedge clk);
            check_data("stall_dout", d0, dout);
            check_rdy("stall_rdy", r0, ram_rdy);
        end
        @(posedge clk);
        #5;
        cen = 1'b1;
        read_check("rd_after_stall", pc);
        end_test("invalidation and stall");

        report_and_finish();
    end

endmodule
